/* files.f */
+incdir+.
mcuPkg.sv
bootRom.sv
dataRam.sv
interruptMaskRegister.sv
memoryMapper.sv
mcuResources.sv
tbClockGen.sv
mcuResources_assertions.sv
mcuResources_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the mcuResources testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

if ! verilator --binary --timing --assert --top-module mcuResources_tb -f files.f; then
	echo "Verilator build failed"
	exit 1
fi

if ! ./obj_dir/VmcuResources_tb > sim.log 2>&1; then
	cat sim.log
	echo "Simulation ended with an error status"
	exit 1
fi

cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
	exit 0
fi

echo "Pass message not found in sim.log"
exit 1

/* mcuResources_tb.sv */
`timescale 1ns/1ps
`include "mcu_params.svh"

module mcuResources_tb import mcuPkg::*;;

	localparam int ramWords = 16;
	localparam int byteWrites = 32;
	localparam int busReads = 16;
	localparam int intRounds = 8;
	// Cycle budget of each test, reset included
	localparam int totalCycles = 9 + 4 + (ramWords * 3 + byteWrites + 2) + (32 + busReads + 2)
		+ 10 + (18 + intRounds * 3 + 2);
	localparam int timeLimitNs = (totalCycles + 50) * 10;

	localparam dataT romTable [0:31] = '{
		16'h3C00, 16'h0E20, 16'hA5F0, 16'h1234, 16'h4B0D, 16'hC0DE, 16'h7F81, 16'h0001,
		16'hE010, 16'h5A5A, 16'h8000, 16'h2468, 16'h9BCF, 16'h0F0F, 16'hF00D, 16'h6C3A,
		16'h1357, 16'hBEEF, 16'h4000, 16'hD2B4, 16'h0A0B, 16'h77E1, 16'h3001, 16'hFFFE,
		16'h8421, 16'h2C7D, 16'h6E00, 16'h1F3B, 16'hA001, 16'h55AA, 16'h0C95, 16'hE000
	};

	logic CLK;
	logic arstN;
	addrT addr;
	dataT cpuDout;
	dataT cpuDin;
	logic rdN;
	logic wr0N;
	logic wr1N;
	dataT busDin;
	dataT gpioIn;
	logic gpioRd;
	logic gpioWr;
	logic gpioAddr;
	logic intS0;
	intVecT intSrc;
	logic int0;
	logic int1;

	logic [31:0] lfsrState;
	dataT ramModel [0:(2 ** `MCU_RAM_AW) - 1];
	intVecT pendModel;
	intVecT maskModel;
	addrT ramAddrs [0:ramWords-1];
	dataT expQ [$];
	int checkCount;
	int errorCount;

	tbClockGen clockGen (
		.CLK(CLK),
		.arstN(arstN)
	);

	mcuResources mcuResources_inst (
		.CLK(CLK),
		.arstN(arstN),
		.addr(addr),
		.cpuDout(cpuDout),
		.cpuDin(cpuDin),
		.rdN(rdN),
		.wr0N(wr0N),
		.wr1N(wr1N),
		.busDin(busDin),
		.gpioIn(gpioIn),
		.gpioRd(gpioRd),
		.gpioWr(gpioWr),
		.gpioAddr(gpioAddr),
		.intS0(intS0),
		.intS1(intSrc[0]),
		.intS2(intSrc[1]),
		.intS3(intSrc[2]),
		.intS4(intSrc[3]),
		.intS5(intSrc[4]),
		.intS6(intSrc[5]),
		.intS7(intSrc[6]),
		.int0(int0),
		.int1(int1)
	);

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			value = {value[30:0], lfsrState[0]};
			lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h80200003 : 32'h0);
		end
		return value;
	endfunction

	function automatic logic isRam(input addrT a);
		return a < (16'd1 << `MCU_RAM_AW);
	endfunction

	function automatic logic isRom(input addrT a);
		return a >= `MCU_ROM_BASE && a < `MCU_ROM_BASE + 16'd32;
	endfunction

	function automatic logic isGpio(input addrT a);
		return (a & 16'hFFFE) == `MCU_GPIO_BASE;
	endfunction

	function automatic logic isInt(input addrT a);
		return (a & 16'hFFFC) == `MCU_INT_BASE;
	endfunction

	function automatic addrT randomOtherAddr();
		addrT a;
		a = addrT'(randBits(16));
		while (isRam(a) || isRom(a) || isGpio(a) || isInt(a)) begin
			a = addrT'(randBits(16));
		end
		return a;
	endfunction

	// Expected read data from the address map and the models
	function automatic dataT expectedRead(input addrT a);
		dataT value;
		if (isRam(a)) begin
			value = ramModel[a[`MCU_RAM_AW-1:0]];
		end else if (isRom(a)) begin
			value = romTable[a[4:0]];
		end else if (isGpio(a)) begin
			value = gpioIn;
		end else if (isInt(a)) begin
			case (a[1:0])
				2'd0: value = {9'd0, pendModel};
				2'd1: value = {9'd0, maskModel};
				2'd2: value = {9'd0, pendModel & maskModel};
				default: value = '0;
			endcase
		end else begin
			value = busDin;
		end
		return value;
	endfunction

	task automatic checkValue(input string what, input logic [15:0] got, input logic [15:0] exp);
		checkCount++;
		assert (got === exp) else begin
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			errorCount++;
		end
	endtask

	task automatic nextCycle();
		@(posedge CLK);
		#1;
	endtask

	task automatic idleCycles(input int n);
		repeat (n) nextCycle();
	endtask

	task automatic readWord(input addrT a);
		addr = a;
		rdN = 1'b0;
		expQ.push_back(expectedRead(a));
		nextCycle();
		rdN = 1'b1;
	endtask

	task automatic writeWord(input addrT a, input dataT d, input logic [1:0] lanes);
		addr = a;
		cpuDout = d;
		wr0N = !lanes[0];
		wr1N = !lanes[1];
		if (isRam(a) && lanes[0]) begin
			ramModel[a[`MCU_RAM_AW-1:0]][7:0] = d[7:0];
		end
		if (isRam(a) && lanes[1]) begin
			ramModel[a[`MCU_RAM_AW-1:0]][15:8] = d[15:8];
		end
		nextCycle();
		wr0N = 1'b1;
		wr1N = 1'b1;
	endtask

	task automatic reportTest(input int num, input string name, input int errorsBefore);
		$display("test %0d %s finished with %0d errors", num, name, errorCount - errorsBefore);
	endtask

	// Interrupt model, strobe checks and read results, once per edge
	initial begin : compareProc
		logic readSampled;
		logic int1Exp;
		intVecT clearBits;
		forever begin
			@(posedge CLK);
			if (!arstN) begin
				pendModel = '0;
				maskModel = '0;
			end else begin
				readSampled = !rdN;
				checkValue("gpioRd", 16'(gpioRd), 16'(isGpio(addr) && !rdN));
				checkValue("gpioWr", 16'(gpioWr), 16'(isGpio(addr) && (!wr0N || !wr1N)));
				if (isGpio(addr) && (!rdN || !wr0N || !wr1N)) begin
					checkValue("gpioAddr", 16'(gpioAddr), 16'(addr[0]));
				end
				checkValue("int0", 16'(int0), 16'(intS0));
				int1Exp = |(pendModel & maskModel);
				clearBits = '0;
				if (isInt(addr) && (!wr0N || !wr1N) && addr[1:0] == 2'd0) begin
					clearBits = cpuDout[6:0];
				end
				if (isInt(addr) && (!wr0N || !wr1N) && addr[1:0] == 2'd1) begin
					maskModel = cpuDout[6:0];
				end
				// Set wins over clear
				pendModel = (pendModel & ~clearBits) | intSrc;
				#2;
				if (readSampled && expQ.size() == 0) begin
					$display("Error at %0t ns: read sampled with no expected value", $time);
					errorCount++;
				end else if (readSampled) begin
					checkValue("cpuDin", cpuDin, expQ.pop_front());
				end
				checkValue("int1", 16'(int1), 16'(int1Exp));
			end
		end
	end

	initial begin : watchdog
		#(timeLimitNs);
		$display("Timeout: run did not finish within %0d ns", timeLimitNs);
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial begin : stimulus
		int errorsBefore;
		logic [1:0] lanes;
		lfsrState = 32'h6a1f8738;
		addr = '0;
		cpuDout = '0;
		rdN = 1'b1;
		wr0N = 1'b1;
		wr1N = 1'b1;
		busDin = '0;
		gpioIn = '0;
		intS0 = 1'b0;
		intSrc = '0;
		checkCount = 0;
		errorCount = 0;
		wait (arstN === 1'b1);
		nextCycle();

		errorsBefore = errorCount;
		checkValue("cpuDin after reset", cpuDin, 16'h0000);
		checkValue("int1 after reset", 16'(int1), 16'h0000);
		checkValue("gpioRd after reset", 16'(gpioRd), 16'h0000);
		checkValue("gpioWr after reset", 16'(gpioWr), 16'h0000);
		readWord(`MCU_INT_BASE + 16'd1);
		idleCycles(2);
		reportTest(1, "reset state", errorsBefore);

		// Full words first so that byte merges never touch unwritten lanes
		errorsBefore = errorCount;
		for (int i = 0; i < ramWords; i++) begin
			ramAddrs[i] = addrT'(randBits(`MCU_RAM_AW));
			writeWord(ramAddrs[i], dataT'(randBits(16)), 2'b11);
		end
		for (int i = 0; i < byteWrites; i++) begin
			lanes = 2'(randBits(2));
			if (lanes == 2'b00) begin
				lanes = 2'b11;
			end
			writeWord(ramAddrs[randBits(4)], dataT'(randBits(16)), lanes);
		end
		for (int i = 0; i < ramWords; i++) begin
			readWord(ramAddrs[i]);
		end
		for (int i = 0; i < ramWords; i++) begin
			readWord(ramAddrs[randBits(4)]);
		end
		idleCycles(2);
		reportTest(2, "RAM byte writes", errorsBefore);

		errorsBefore = errorCount;
		for (int i = 0; i < 32; i++) begin
			readWord(`MCU_ROM_BASE + addrT'(i));
		end
		for (int i = 0; i < busReads; i++) begin
			busDin = dataT'(randBits(16));
			readWord(randomOtherAddr());
		end
		busDin = '0;
		idleCycles(2);
		reportTest(3, "ROM and external bus", errorsBefore);

		errorsBefore = errorCount;
		gpioIn = dataT'(randBits(16));
		readWord(`MCU_GPIO_BASE);
		readWord(`MCU_GPIO_BASE + 16'd1);
		writeWord(`MCU_GPIO_BASE + 16'd1, dataT'(randBits(16)), 2'b11);
		writeWord(`MCU_GPIO_BASE, dataT'(randBits(16)), 2'b01);
		readWord(ramAddrs[0]);
		gpioIn = dataT'(randBits(16));
		readWord(`MCU_GPIO_BASE + 16'd1);
		writeWord(16'h9000, dataT'(randBits(16)), 2'b10);
		idleCycles(2);
		reportTest(4, "GPIO window", errorsBefore);

		errorsBefore = errorCount;
		intSrc = 7'b0000101;
		nextCycle();
		intSrc = '0;
		readWord(`MCU_INT_BASE);
		writeWord(`MCU_INT_BASE + 16'd1, 16'h0004, 2'b11);
		idleCycles(2);
		readWord(`MCU_INT_BASE + 16'd2);
		// Source 3 still high during the clear
		intSrc = 7'b0000100;
		writeWord(`MCU_INT_BASE, 16'h0004, 2'b11);
		intSrc = '0;
		readWord(`MCU_INT_BASE);
		writeWord(`MCU_INT_BASE, 16'h0005, 2'b11);
		idleCycles(2);
		readWord(`MCU_INT_BASE);
		intS0 = 1'b1;
		nextCycle();
		intS0 = 1'b0;
		nextCycle();
		for (int i = 0; i < intRounds; i++) begin
			intSrc = intVecT'(randBits(7));
			intS0 = randBits(1) != 32'd0;
			writeWord(`MCU_INT_BASE + 16'd1, dataT'(randBits(7)), 2'b11);
			intSrc = '0;
			readWord(`MCU_INT_BASE + addrT'(randBits(2)));
			writeWord(`MCU_INT_BASE, 16'h007F, 2'b11);
		end
		intS0 = 1'b0;
		idleCycles(2);
		reportTest(5, "interrupts", errorsBefore);

		// Let the checks of the last edge complete
		@(negedge CLK);
		if (expQ.size() != 0) begin
			$display("Error: %0d reads never produced a result", expQ.size());
			errorCount++;
		end
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* mcuResources_assertions.sv */
`timescale 1ns/1ps

module mcuResources_assertions import mcuPkg::*; #(
	parameter bit mapperSide = 1'b1
) (
	input logic CLK,
	input logic arstN,
	input logic gpioRd,
	input logic gpioWr,
	input logic ramEn,
	input logic ramWe,
	input logic int1,
	input intVecT active
);

	if (mapperSide) begin : mapperProps
		gpioExclusive: assert property (@(posedge CLK) disable iff (!arstN) !(gpioRd && gpioWr))
			else $error("gpioRd and gpioWr are high in the same cycle");

		ramWriteEnabled: assert property (@(posedge CLK) disable iff (!arstN) ramWe |-> ramEn)
			else $error("ramWe is high while ramEn is low");
	end else begin : intProps
		// Combined request lags the active bits by one edge
		int1Follows: assert property (@(posedge CLK) disable iff (!arstN) int1 == $past(|active))
			else $error("int1 does not follow the active bits of the previous cycle");
	end

endmodule

// Mapper side, interrupt ports tied off
bind memoryMapper mcuResources_assertions #(.mapperSide(1'b1)) mapperChecks (
	.CLK(CLK),
	.arstN(arstN),
	.gpioRd(gpioRd),
	.gpioWr(gpioWr),
	.ramEn(ramEn),
	.ramWe(ramWe),
	.int1(1'b0),
	.active('0)
);

bind interruptMaskRegister mcuResources_assertions #(.mapperSide(1'b0)) intChecks (
	.CLK(CLK),
	.arstN(arstN),
	.gpioRd(1'b0),
	.gpioWr(1'b0),
	.ramEn(1'b0),
	.ramWe(1'b0),
	.int1(int1),
	.active(active)
);

/* tbClockGen.sv */
`timescale 1ns/1ps

module tbClockGen (
	output logic CLK,
	output logic arstN
);

	localparam int resetCycles = 8;

	// 10 ns period
	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// Release just after an edge so the first active edge is clean
	initial begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge CLK);
		#1 arstN = 1'b1;
	end

endmodule

/* mcuResources.sv */
`timescale 1ns/1ps
`include "mcu_params.svh"

module mcuResources import mcuPkg::*; (
	input logic CLK,
	input logic arstN,

	// CPU side
	input addrT addr,
	input dataT cpuDout,
	output dataT cpuDin,
	input logic rdN,
	input logic wr0N,
	input logic wr1N,

	// External bus
	input dataT busDin,

	// GPIO
	input dataT gpioIn,
	output logic gpioRd,
	output logic gpioWr,
	output logic gpioAddr,

	// Interrupt sources
	input logic intS0,
	input logic intS1,
	input logic intS2,
	input logic intS3,
	input logic intS4,
	input logic intS5,
	input logic intS6,
	input logic intS7,

	output logic int0,
	output logic int1
);

	dataT romQ;
	dataT ramQ;
	dataT intDout;
	logic ramEn;
	logic ramWe;
	logic [1:0] byteEn;
	logic intRd;
	logic intWr;
	logic [1:0] intAddr;
	intVecT intS;

	// Source 1 in bit 0
	assign intS = {intS7, intS6, intS5, intS4, intS3, intS2, intS1};

	memoryMapper memoryMapperInst (
		.CLK(CLK),
		.arstN(arstN),
		.addr(addr),
		.rdN(rdN),
		.wr0N(wr0N),
		.wr1N(wr1N),
		.cpuDin(cpuDin),
		.busDin(busDin),
		.romQ(romQ),
		.ramQ(ramQ),
		.intDout(intDout),
		.gpioIn(gpioIn),
		.ramEn(ramEn),
		.ramWe(ramWe),
		.byteEn(byteEn),
		.intRd(intRd),
		.intWr(intWr),
		.intAddr(intAddr),
		.gpioRd(gpioRd),
		.gpioWr(gpioWr),
		.gpioAddr(gpioAddr)
	);

	bootRom bootRomInst (
		.romAddr(addr[`MCU_ROM_AW-1:0]),
		.romQ(romQ)
	);

	dataRam dataRamInst (
		.CLK(CLK),
		.ramEn(ramEn),
		.ramWe(ramWe),
		.byteEn(byteEn),
		.ramAddr(addr[`MCU_RAM_AW-1:0]),
		.ramDin(cpuDout),
		.ramQ(ramQ)
	);

	interruptMaskRegister interruptMaskRegisterInst (
		.CLK(CLK),
		.arstN(arstN),
		.intRd(intRd),
		.intWr(intWr),
		.intAddr(intAddr),
		.intDin(cpuDout),
		.intS(intS),
		.intDout(intDout),
		.int1(int1)
	);

	// Non-maskable request goes straight out
	assign int0 = intS0;

endmodule

/* memoryMapper.sv */
`timescale 1ns/1ps
`include "mcu_params.svh"

module memoryMapper import mcuPkg::*; (
	input logic CLK,
	input logic arstN,

	// CPU side
	input addrT addr,
	input logic rdN,
	input logic wr0N,
	input logic wr1N,
	output dataT cpuDin,

	// Read sources
	input dataT busDin,
	input dataT romQ,
	input dataT ramQ,
	input dataT intDout,
	input dataT gpioIn,

	// RAM control
	output logic ramEn,
	output logic ramWe,
	output logic [1:0] byteEn,

	// Interrupt unit control
	output logic intRd,
	output logic intWr,
	output logic [1:0] intAddr,

	// GPIO control
	output logic gpioRd,
	output logic gpioWr,
	output logic gpioAddr
);

	localparam addrT romBase = `MCU_ROM_BASE;
	localparam addrT gpioBase = `MCU_GPIO_BASE;
	localparam addrT intBase = `MCU_INT_BASE;

	logic rdCycle;
	logic wrCycle;
	logic ramSel;
	logic romSel;
	logic gpioSel;
	logic intSel;
	dataT otherData;
	dataT readReg;
	logic srcRam;

	assign rdCycle = !rdN;
	assign wrCycle = !wr0N || !wr1N;

	// Region decode
	assign ramSel = addr[15:`MCU_RAM_AW] == '0;
	assign romSel = addr[15:`MCU_ROM_AW] == romBase[15:`MCU_ROM_AW];
	assign gpioSel = addr[15:1] == gpioBase[15:1];
	assign intSel = addr[15:2] == intBase[15:2];

	// RAM strobes, byte lanes follow the write strobes
	assign ramEn = ramSel && (rdCycle || wrCycle);
	assign ramWe = ramSel && wrCycle;
	assign byteEn = {!wr1N, !wr0N};

	assign intRd = intSel && rdCycle;
	assign intWr = intSel && wrCycle;
	assign intAddr = addr[1:0];

	assign gpioRd = gpioSel && rdCycle;
	assign gpioWr = gpioSel && wrCycle;
	assign gpioAddr = (gpioRd || gpioWr) && addr[0];

	// Non-RAM source for the current read
	always_comb begin
		if (intSel) begin
			otherData = intDout;
		end else if (romSel) begin
			otherData = romQ;
		end else if (gpioSel) begin
			otherData = gpioIn;
		end else begin
			otherData = busDin;
		end
	end

	// Captured at the same edge where the RAM registers its word
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			readReg <= '0;
			srcRam <= 1'b0;
		end else if (rdCycle) begin
			readReg <= otherData;
			srcRam <= ramSel;
		end
	end

	assign cpuDin = srcRam ? ramQ : readReg;

endmodule

/* interruptMaskRegister.sv */
`timescale 1ns/1ps
`include "mcu_params.svh"

module interruptMaskRegister import mcuPkg::*; (
	input logic CLK,
	input logic arstN,
	input logic intRd,
	input logic intWr,
	input logic [1:0] intAddr,
	input dataT intDin,
	input intVecT intS,
	output dataT intDout,
	output logic int1
);

	localparam int padWidth = 16 - `MCU_INT_COUNT;

	intVecT pending;
	intVecT mask;
	intVecT active;
	intVecT clearBits;
	dataT regValue;

	assign active = pending & mask;

	// Write one to clear
	assign clearBits = (intWr && intAddr == `MCU_INT_REG_PENDING) ?
		intDin[`MCU_INT_COUNT-1:0] : '0;

	// A source that is high wins over a clear in the same cycle
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			pending <= '0;
		end else begin
			pending <= (pending & ~clearBits) | intS;
		end
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			mask <= '0;
		end else if (intWr && intAddr == `MCU_INT_REG_MASK) begin
			mask <= intDin[`MCU_INT_COUNT-1:0];
		end
	end

	// Combined request, one cycle behind the active bits
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			int1 <= 1'b0;
		end else begin
			int1 <= |active;
		end
	end

	// Register read decode
	always_comb begin
		case (intAddr)
			`MCU_INT_REG_PENDING: regValue = {{padWidth{1'b0}}, pending};
			`MCU_INT_REG_MASK: regValue = {{padWidth{1'b0}}, mask};
			`MCU_INT_REG_ACTIVE: regValue = {{padWidth{1'b0}}, active};
			default: regValue = '0;
		endcase
	end

	assign intDout = intRd ? regValue : '0;

endmodule

/* dataRam.sv */
`timescale 1ns/1ps
`include "mcu_params.svh"

module dataRam import mcuPkg::*; (
	input logic CLK,
	input logic ramEn,
	input logic ramWe,
	input logic [1:0] byteEn,
	input logic [`MCU_RAM_AW-1:0] ramAddr,
	input dataT ramDin,
	output dataT ramQ
);

	localparam int depth = 2 ** `MCU_RAM_AW;

	dataT mem [0:depth-1];

	// Byte lane writes
	always_ff @(posedge CLK) begin
		if (ramEn && ramWe) begin
			if (byteEn[0]) begin
				mem[ramAddr][7:0] <= ramDin[7:0];
			end
			if (byteEn[1]) begin
				mem[ramAddr][15:8] <= ramDin[15:8];
			end
		end
	end

	// Registered read, held while the RAM is idle or writing
	always_ff @(posedge CLK) begin
		if (ramEn && !ramWe) begin
			ramQ <= mem[ramAddr];
		end
	end

endmodule

/* bootRom.sv */
`timescale 1ns/1ps

module bootRom import mcuPkg::*; (
	input logic [4:0] romAddr,
	output dataT romQ
);

	// Fixed boot image
	always_comb begin
		case (romAddr)
			5'd0: romQ = 16'h3C00;
			5'd1: romQ = 16'h0E20;
			5'd2: romQ = 16'hA5F0;
			5'd3: romQ = 16'h1234;
			5'd4: romQ = 16'h4B0D;
			5'd5: romQ = 16'hC0DE;
			5'd6: romQ = 16'h7F81;
			5'd7: romQ = 16'h0001;
			5'd8: romQ = 16'hE010;
			5'd9: romQ = 16'h5A5A;
			5'd10: romQ = 16'h8000;
			5'd11: romQ = 16'h2468;
			5'd12: romQ = 16'h9BCF;
			5'd13: romQ = 16'h0F0F;
			5'd14: romQ = 16'hF00D;
			5'd15: romQ = 16'h6C3A;
			5'd16: romQ = 16'h1357;
			5'd17: romQ = 16'hBEEF;
			5'd18: romQ = 16'h4000;
			5'd19: romQ = 16'hD2B4;
			5'd20: romQ = 16'h0A0B;
			5'd21: romQ = 16'h77E1;
			5'd22: romQ = 16'h3001;
			5'd23: romQ = 16'hFFFE;
			5'd24: romQ = 16'h8421;
			5'd25: romQ = 16'h2C7D;
			5'd26: romQ = 16'h6E00;
			5'd27: romQ = 16'h1F3B;
			5'd28: romQ = 16'hA001;
			5'd29: romQ = 16'h55AA;
			5'd30: romQ = 16'h0C95;
			default: romQ = 16'hE000;
		endcase
	end

endmodule

/* mcuPkg.sv */
package mcuPkg;

	// CPU address, one 16-bit word
	typedef logic [15:0] addrT;

	// CPU data word
	typedef logic [15:0] dataT;

	// Maskable sources 1 to 7, bit 0 holds source 1
	typedef logic [6:0] intVecT;

endpackage

/* mcu_params.svh */
`ifndef MCU_PARAMS_SVH
`define MCU_PARAMS_SVH

// Data RAM word address width, RAM sits at 0x0000 up to 0x1FFF
`define MCU_RAM_AW 13

// Boot ROM base and its word address width (32 words)
`define MCU_ROM_BASE 16'hE000
`define MCU_ROM_AW 5

// GPIO window, two words selected by address bit 0
`define MCU_GPIO_BASE 16'hF000

// Interrupt unit, four registers selected by address bits 1:0
`define MCU_INT_BASE 16'hF010

// Maskable interrupt sources 1 to 7
`define MCU_INT_COUNT 7

// Interrupt unit register indices
`define MCU_INT_REG_PENDING 2'd0
`define MCU_INT_REG_MASK 2'd1
`define MCU_INT_REG_ACTIVE 2'd2

`endif
